/* nor_bus_pkg.sv */
/*
  NOR-flash side bus definitions
  - bus widths
  - NOR cycle codes carried in the top address bits
  - request struct from the command FSM to the bus master
*/

package nor_bus_pkg;

    localparam int NOR_CYCLE_BITS = 6;
    localparam int WB_ADR_BITS    = 32;
    localparam int WB_DAT_BITS    = 16; // one flash word per transfer

    // cycle code, placed in adr[31:26]
    typedef enum logic [NOR_CYCLE_BITS-1:0] {
        NOR_RESET        = 6'd0,
        NOR_READ         = 6'd1,
        NOR_WRITE        = 6'd2,
        NOR_ERASE_SECTOR = 6'd3
    } nor_cycle_t;

    // one single transfer
    typedef struct packed {
        logic [WB_ADR_BITS-1:0] adr; // {cycle code, flash address}
        logic                   we;
        logic [WB_DAT_BITS-1:0] dat; // write data, ignored on reads
    } bus_req_t;

endpackage

/* qspi_pkg.sv */
/*
  SPI side definitions
  - address, data and shift widths
  - cycle counts per protocol phase
  - command codes and protocol states
  - shifter phase settings and per-command attributes
*/

package qspi_pkg;

    localparam int ADDR_BITS    = 26; // low address bits that are used
    localparam int DATA_BITS    = nor_bus_pkg::WB_DAT_BITS;
    localparam int SHIFT_BITS   = 32;
    localparam int CNT_BITS     = 8;  // cycle counter width
    localparam int ADDR_CYCLES  = 8;  // quad nibbles
    localparam int DATA_CYCLES  = 4;  // quad nibbles
    localparam int CMD_CYCLES   = 8;  // single-SPI bits
    localparam int DUMMY_CYCLES = 20; // fast read stall

    typedef enum logic [7:0] {
        CMD_READ       = 8'h03,
        CMD_FAST_READ  = 8'h0B,
        CMD_SECT_ERASE = 8'hD8,
        CMD_WRITE_THRU = 8'hF8,
        CMD_LOOPBACK   = 8'hFA
    } spi_cmd_t;

    typedef enum logic [2:0] {
        ST_CMD,
        ST_ADDR,
        ST_FAST_READ_STALL,
        ST_READ_DATA,
        ST_WRITE_DATA,
        ST_LOOPBACK_DATA
    } spi_state_t;

    // how the shifter runs the current phase
    typedef struct packed {
        logic                quad;       // 0 = single bit on sio[0]
        logic                dir_out;    // 1 = drive sio
        logic [CNT_BITS-1:0] last_cycle; // cycle count minus one
    } phase_cfg_t;

    typedef struct packed {
        spi_state_t              data_state;  // next state after address
        logic                    req_at_addr; // bus request once address is in
        logic                    req_at_data; // bus request once data is in
        logic                    we;
        nor_bus_pkg::nor_cycle_t nor_cycle;
    } cmd_attr_t;

endpackage

/* qspi_shifter.sv */
/*
  SPI bit engine
  - SCK and CE synchronizers with edge detect
  - phase cycle counter and done strobe
  - single or quad shift-in, registered nibble output
*/

`timescale 1ns/1ns

module qspi_shifter (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            sck_i,
    input  logic                            sce_i,     // active low
    input  logic [3:0]                      sio_i,
    input  qspi_pkg::phase_cfg_t            phase_i,
    input  logic [qspi_pkg::SHIFT_BITS-1:0] tx_data_i,
    output logic [3:0]                      sio_o,
    output logic                            sio_oe_o,
    output logic [qspi_pkg::SHIFT_BITS-1:0] rx_data_o,
    output logic                            done_o,
    output logic                            cs_idle_o
);

    logic [1:0]                    sck_sync;
    logic [1:0]                    sce_sync;
    logic                          sck_q;     // edge reference
    logic                          sck_rise;
    logic                          sck_fall;
    logic [qspi_pkg::CNT_BITS-1:0] cycle_cnt;
    logic                          last_cycle;
    logic [2:0]                    nib_idx;   // 8 nibbles in the tx word

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            sck_sync <= 2'b00;
            sce_sync <= 2'b11; // deselected
            sck_q    <= 1'b0;
        end else begin
            sck_sync <= {sck_sync[0], sck_i};
            sce_sync <= {sce_sync[0], sce_i};
            sck_q    <= sck_sync[1];
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_q;
    assign sck_fall  = ~sck_sync[1] & sck_q;
    assign cs_idle_o = sce_sync[1];
    assign sio_oe_o  = ~cs_idle_o & phase_i.dir_out;

    assign last_cycle = (cycle_cnt == phase_i.last_cycle);

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            cycle_cnt <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0; // strobe
            if (cs_idle_o) begin
                cycle_cnt <= '0;
            end else if (sck_rise) begin
                if (last_cycle) begin
                    cycle_cnt <= '0; // next phase starts over
                    done_o    <= 1'b1;
                end else begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                end
            end
        end
    end

    // input sampling on rising SCK
    always_ff @(posedge clk_i) begin
        if (sck_rise && !cs_idle_o && !phase_i.dir_out) begin
            if (phase_i.quad)
                rx_data_o <= {rx_data_o[qspi_pkg::SHIFT_BITS-5:0], sio_i};
            else
                rx_data_o <= {rx_data_o[qspi_pkg::SHIFT_BITS-2:0], sio_i[0]};
        end
    end

    // MSB nibble first
    assign nib_idx = phase_i.last_cycle[2:0] - cycle_cnt[2:0];

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i)
            sio_o <= 4'h0;
        else if (sck_fall)
            sio_o <= tx_data_i[{nib_idx, 2'b00} +: 4]; // master samples on next rise
    end

    // phase changes only once the counter is back at zero
    a_cnt_range: assert property (@(posedge clk_i) disable iff (reset_i)
        cycle_cnt <= phase_i.last_cycle);
    a_done_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        done_o |=> !done_o);

endmodule

/* qspi_cmd_table.sv */
/*
  Protocol configuration lookup
  - shifter phase settings per protocol state
  - bus attributes and next state per command code
*/

`timescale 1ns/1ns

module qspi_cmd_table (
    input  qspi_pkg::spi_state_t state_i,
    input  qspi_pkg::spi_cmd_t   cmd_i,
    output qspi_pkg::phase_cfg_t phase_o,
    output qspi_pkg::cmd_attr_t  attr_o
);

    function automatic qspi_pkg::phase_cfg_t mk_phase(input logic quad,
                                                      input logic dir_out,
                                                      input int   cycles);
        qspi_pkg::phase_cfg_t cfg;
        cfg.quad       = quad;
        cfg.dir_out    = dir_out;
        cfg.last_cycle = qspi_pkg::CNT_BITS'(cycles - 1);
        return cfg;
    endfunction

    always_comb begin
        case (state_i)
            qspi_pkg::ST_ADDR:            phase_o = mk_phase(1'b1, 1'b0, qspi_pkg::ADDR_CYCLES);
            qspi_pkg::ST_FAST_READ_STALL: phase_o = mk_phase(1'b1, 1'b0, qspi_pkg::DUMMY_CYCLES);
            qspi_pkg::ST_READ_DATA,
            qspi_pkg::ST_LOOPBACK_DATA:   phase_o = mk_phase(1'b1, 1'b1, qspi_pkg::DATA_CYCLES);
            qspi_pkg::ST_WRITE_DATA:      phase_o = mk_phase(1'b1, 1'b0, qspi_pkg::DATA_CYCLES);
            default:                      phase_o = mk_phase(1'b0, 1'b0, qspi_pkg::CMD_CYCLES);
        endcase
    end

    always_comb begin
        // unknown codes: back to cmd, no bus cycle
        attr_o.data_state  = qspi_pkg::ST_CMD;
        attr_o.req_at_addr = 1'b0;
        attr_o.req_at_data = 1'b0;
        attr_o.we          = 1'b0;
        attr_o.nor_cycle   = nor_bus_pkg::NOR_RESET;
        case (cmd_i)
            qspi_pkg::CMD_READ: begin
                attr_o.data_state  = qspi_pkg::ST_READ_DATA;
                attr_o.req_at_addr = 1'b1;
                attr_o.nor_cycle   = nor_bus_pkg::NOR_READ;
            end
            qspi_pkg::CMD_FAST_READ: begin
                attr_o.data_state  = qspi_pkg::ST_FAST_READ_STALL; // dummies first
                attr_o.req_at_addr = 1'b1; // read runs during the stall
                attr_o.nor_cycle   = nor_bus_pkg::NOR_READ;
            end
            qspi_pkg::CMD_SECT_ERASE: begin
                attr_o.req_at_addr = 1'b1; // address only
                attr_o.we          = 1'b1;
                attr_o.nor_cycle   = nor_bus_pkg::NOR_ERASE_SECTOR;
            end
            qspi_pkg::CMD_WRITE_THRU: begin
                attr_o.data_state  = qspi_pkg::ST_WRITE_DATA;
                attr_o.req_at_data = 1'b1;
                attr_o.we          = 1'b1;
                attr_o.nor_cycle   = nor_bus_pkg::NOR_WRITE;
            end
            qspi_pkg::CMD_LOOPBACK: attr_o.data_state = qspi_pkg::ST_LOOPBACK_DATA;
            default: ;
        endcase
    end

endmodule

/* qspi_cmd_fsm.sv */
/*
  Flash command protocol FSM
  - state sequence cmd, addr, optional stall, data
  - latches command, address and write data from the shifter
  - one-cycle bus request pulse with the request word
*/

`timescale 1ns/1ns

module qspi_cmd_fsm (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            done_i,
    input  logic                            cs_idle_i,
    input  logic [qspi_pkg::SHIFT_BITS-1:0] rx_data_i,
    input  qspi_pkg::cmd_attr_t             attr_i,
    output qspi_pkg::spi_state_t            state_o,
    output qspi_pkg::spi_cmd_t              cmd_o,
    output logic [qspi_pkg::ADDR_BITS-1:0]  addr_o,
    output logic                            req_valid_o,
    output nor_bus_pkg::bus_req_t           req_o
);

    logic [qspi_pkg::DATA_BITS-1:0] wdata_q; // write-through word

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            state_o     <= qspi_pkg::ST_CMD;
            cmd_o       <= qspi_pkg::spi_cmd_t'(8'h00);
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= 1'b0;
            if (cs_idle_i) begin
                state_o <= qspi_pkg::ST_CMD; // CE high aborts any phase
            end else if (done_i) begin
                case (state_o)
                    qspi_pkg::ST_CMD: begin
                        cmd_o   <= qspi_pkg::spi_cmd_t'(rx_data_i[7:0]);
                        state_o <= qspi_pkg::ST_ADDR;
                    end
                    qspi_pkg::ST_ADDR: begin
                        state_o     <= attr_i.data_state;
                        req_valid_o <= attr_i.req_at_addr; // reads and erase
                    end
                    qspi_pkg::ST_FAST_READ_STALL: state_o <= qspi_pkg::ST_READ_DATA;
                    qspi_pkg::ST_WRITE_DATA: begin
                        state_o     <= qspi_pkg::ST_CMD;
                        req_valid_o <= attr_i.req_at_data;
                    end
                    default: state_o <= qspi_pkg::ST_CMD; // end of data phase
                endcase
            end
        end
    end

    // payload latches
    always_ff @(posedge clk_i) begin
        if (done_i && !cs_idle_i) begin
            case (state_o)
                qspi_pkg::ST_ADDR:       addr_o  <= rx_data_i[qspi_pkg::ADDR_BITS-1:0];
                qspi_pkg::ST_WRITE_DATA: wdata_q <= rx_data_i[qspi_pkg::DATA_BITS-1:0];
                default: ;
            endcase
        end
    end

    // latches are already updated when req_valid_o is high
    always_comb begin
        req_o.adr = {attr_i.nor_cycle, addr_o};
        req_o.we  = attr_i.we;
        req_o.dat = wdata_q;
    end

    a_req_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_o |=> !req_valid_o);

endmodule

/* wb_master.sv */
/*
  Single-transfer bus master
  - starts one transfer per request, holds it until ack
  - keeps the last read word for the SPI side
*/

`timescale 1ns/1ns

module wb_master (
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic                               req_valid_i,
    input  nor_bus_pkg::bus_req_t              req_i,
    input  logic                               wb_ack_i,
    input  logic [qspi_pkg::DATA_BITS-1:0]     wb_dat_i,
    output logic                               wb_cyc_o,
    output logic                               wb_stb_o,
    output logic                               wb_we_o,
    output logic [nor_bus_pkg::WB_ADR_BITS-1:0] wb_adr_o,
    output logic [qspi_pkg::DATA_BITS-1:0]     wb_dat_o,
    output logic [qspi_pkg::DATA_BITS-1:0]     rd_data_o
);

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
        end else if (!wb_cyc_o) begin
            if (req_valid_i) begin // accept a request when idle
                wb_cyc_o <= 1'b1;
                wb_stb_o <= 1'b1;
                wb_we_o  <= req_i.we;
            end
        end else if (wb_ack_i) begin
            wb_cyc_o <= 1'b0; // done next cycle
            wb_stb_o <= 1'b0;
        end
    end

    // address and write data held through the transfer
    always_ff @(posedge clk_i) begin
        if (!wb_cyc_o && req_valid_i) begin
            wb_adr_o <= req_i.adr;
            wb_dat_o <= req_i.dat;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wb_cyc_o && wb_ack_i)
            rd_data_o <= wb_dat_i; // write acks load it too
    end

    // a request while busy would be lost
    a_req_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_i |-> !wb_cyc_o);

endmodule

/* qspi_flash_bridge.sv */
/*
  Quad-SPI flash emulation front end, top level
  - SPI shifter, command table, protocol FSM, bus master
  - tx word select between loopback address and read data
*/

`timescale 1ns/1ns

module qspi_flash_bridge (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                sck_i,
    input  logic                                sce_i,   // active low
    input  logic [3:0]                          sio_i,
    output logic [3:0]                          sio_o,
    output logic                                sio_oe_o,
    output logic                                wb_cyc_o,
    output logic                                wb_stb_o,
    output logic                                wb_we_o,
    output logic [nor_bus_pkg::WB_ADR_BITS-1:0] wb_adr_o,
    output logic [qspi_pkg::DATA_BITS-1:0]      wb_dat_o,
    input  logic                                wb_ack_i,
    input  logic [qspi_pkg::DATA_BITS-1:0]      wb_dat_i
);

    qspi_pkg::phase_cfg_t            phase;
    qspi_pkg::cmd_attr_t             attr;
    qspi_pkg::spi_state_t            state;
    qspi_pkg::spi_cmd_t              cmd;
    logic [qspi_pkg::ADDR_BITS-1:0]  addr;
    logic [qspi_pkg::SHIFT_BITS-1:0] rx_data;
    logic [qspi_pkg::SHIFT_BITS-1:0] tx_data;
    logic [qspi_pkg::DATA_BITS-1:0]  rd_data;
    logic                            done;
    logic                            cs_idle;
    logic                            req_valid;
    nor_bus_pkg::bus_req_t           req;

    // loopback echoes the address, low nibbles go out
    assign tx_data = (state == qspi_pkg::ST_LOOPBACK_DATA) ?
                     qspi_pkg::SHIFT_BITS'(addr) : qspi_pkg::SHIFT_BITS'(rd_data);

    qspi_shifter i_shifter (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .sck_i     (sck_i),
        .sce_i     (sce_i),
        .sio_i     (sio_i),
        .phase_i   (phase),
        .tx_data_i (tx_data),
        .sio_o     (sio_o),
        .sio_oe_o  (sio_oe_o),
        .rx_data_o (rx_data),
        .done_o    (done),
        .cs_idle_o (cs_idle)
    );

    qspi_cmd_table i_table (
        .state_i (state),
        .cmd_i   (cmd),
        .phase_o (phase),
        .attr_o  (attr)
    );

    qspi_cmd_fsm i_fsm (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .done_i      (done),
        .cs_idle_i   (cs_idle),
        .rx_data_i   (rx_data),
        .attr_i      (attr),
        .state_o     (state),
        .cmd_o       (cmd),
        .addr_o      (addr),
        .req_valid_o (req_valid),
        .req_o       (req)
    );

    wb_master i_wb_master (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .wb_ack_i    (wb_ack_i),
        .wb_dat_i    (wb_dat_i),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_o    (wb_dat_o),
        .rd_data_o   (rd_data)
    );

endmodule

/* tb_qspi_flash_bridge.sv */
/*
  Testbench for the quad-SPI flash bridge
  - SPI master tasks for command, address, stall and data phases
  - bus responder with random ack delay, records each transfer
  - reference model of bus transfers and read-back nibbles
*/

`timescale 1ns/1ns

module tb_qspi_flash_bridge;

    localparam int SCK_HALF = 8;   // clk cycles per SCK level
    localparam int N_TRANS  = 200;
    localparam int TIMEOUT  = 200; // clk cycles allowed per wait loop

    logic                                clk_i;
    logic                                reset_i;
    logic                                sck_i;
    logic                                sce_i;
    logic [3:0]                          sio_i;
    logic [3:0]                          sio_o;
    logic                                sio_oe_o;
    logic                                wb_cyc_o;
    logic                                wb_stb_o;
    logic                                wb_we_o;
    logic [nor_bus_pkg::WB_ADR_BITS-1:0] wb_adr_o;
    logic [qspi_pkg::DATA_BITS-1:0]      wb_dat_o;
    logic                                wb_ack_i;
    logic [qspi_pkg::DATA_BITS-1:0]      wb_dat_i;

    integer                              seed;
    int                                  xfer_count; // acked transfers so far
    logic [nor_bus_pkg::WB_ADR_BITS-1:0] seen_adr;   // last transfer as seen at ack
    logic                                seen_we;
    logic [qspi_pkg::DATA_BITS-1:0]      seen_dat;
    logic [qspi_pkg::DATA_BITS-1:0]      rsp_data;   // word returned on that ack

    qspi_flash_bridge i_dut (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .sck_i    (sck_i),
        .sce_i    (sce_i),
        .sio_i    (sio_i),
        .sio_o    (sio_o),
        .sio_oe_o (sio_oe_o),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_ack_i (wb_ack_i),
        .wb_dat_i (wb_dat_i)
    );

    always #5 clk_i = ~clk_i; // 10 ns period

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        $display("Test FAILED");
        $fatal(1, "wait timeout");
    endtask

    function automatic logic is_known_cmd(input logic [7:0] code);
        return code == qspi_pkg::CMD_READ || code == qspi_pkg::CMD_FAST_READ ||
               code == qspi_pkg::CMD_SECT_ERASE || code == qspi_pkg::CMD_WRITE_THRU ||
               code == qspi_pkg::CMD_LOOPBACK;
    endfunction

    // one SCK period starting at a falling clk edge with SCK low
    task automatic spi_cycle(input logic [3:0] out_nib, input logic exp_oe,
                             output logic [3:0] in_nib);
        sio_i = out_nib; // changes while SCK is low
        repeat (SCK_HALF) @(negedge clk_i);
        check_value("sio_oe_o", 32'(sio_oe_o), 32'(exp_oe));
        in_nib = sio_o;  // master samples just before the rise
        sck_i  = 1'b1;
        repeat (SCK_HALF) @(negedge clk_i);
        sck_i = 1'b0;
    endtask

    // waits for the ack count to reach target, then for cyc to drop
    task automatic wait_transfer(input int target);
        int n;
        n = 0;
        while (xfer_count < target) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT)
                report_timeout("a bus ack");
        end
        n = 0;
        while (wb_cyc_o) begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT)
                report_timeout("wb_cyc_o to fall");
        end
        check_value("transfer count", 32'(xfer_count), 32'(target));
    endtask

    task automatic run_transaction(input logic [7:0] code, input logic [31:0] addr_word,
                                   input logic [15:0] wdata);
        logic [3:0]                     nib;
        logic [15:0]                    rx_word;
        logic [qspi_pkg::ADDR_BITS-1:0] addr;
        logic                           exp_xfer;
        logic                           exp_we;
        logic                           is_read;
        nor_bus_pkg::nor_cycle_t        exp_cycle;
        int                             start_count;
        int                             i;
        addr        = addr_word[qspi_pkg::ADDR_BITS-1:0]; // top bits dropped
        start_count = xfer_count;
        rx_word     = '0;
        is_read     = (code == qspi_pkg::CMD_READ) || (code == qspi_pkg::CMD_FAST_READ);
        // expected bus attributes per command
        exp_xfer  = 1'b1;
        exp_we    = 1'b0;
        exp_cycle = nor_bus_pkg::NOR_READ;
        if (code == qspi_pkg::CMD_SECT_ERASE) begin
            exp_we    = 1'b1;
            exp_cycle = nor_bus_pkg::NOR_ERASE_SECTOR;
        end else if (code == qspi_pkg::CMD_WRITE_THRU) begin
            exp_we    = 1'b1;
            exp_cycle = nor_bus_pkg::NOR_WRITE;
        end else if (!is_read) begin
            exp_xfer = 1'b0; // loopback and unknown codes
        end

        sce_i = 1'b0;
        for (i = qspi_pkg::CMD_CYCLES - 1; i >= 0; i--)
            spi_cycle({3'b000, code[i]}, 1'b0, nib); // single SPI with MSB first
        for (i = qspi_pkg::ADDR_CYCLES - 1; i >= 0; i--)
            spi_cycle(addr_word[i*4 +: 4], 1'b0, nib);
        if (code == qspi_pkg::CMD_FAST_READ) begin
            for (i = 0; i < qspi_pkg::DUMMY_CYCLES; i++)
                spi_cycle(4'($random(seed)), 1'b0, nib); // dummy nibbles are ignored
        end
        if (is_read || code == qspi_pkg::CMD_LOOPBACK) begin
            for (i = 0; i < qspi_pkg::DATA_CYCLES; i++) begin
                spi_cycle(4'h0, 1'b1, nib);
                rx_word = {rx_word[11:0], nib}; // MSB nibble first
            end
        end
        if (code == qspi_pkg::CMD_WRITE_THRU) begin
            for (i = qspi_pkg::DATA_CYCLES - 1; i >= 0; i--)
                spi_cycle(wdata[i*4 +: 4], 1'b0, nib);
        end

        repeat (2) @(negedge clk_i);
        // back in the command phase, so no output phase follows
        check_value("sio_oe_o after last phase", 32'(sio_oe_o), 32'd0);
        sce_i = 1'b1; // deselect
        repeat (6) @(negedge clk_i);
        check_value("sio_oe_o while deselected", 32'(sio_oe_o), 32'd0);

        if (exp_xfer) begin
            wait_transfer(start_count + 1); // exactly one
            check_value("wb_adr_o", seen_adr, {exp_cycle, addr});
            check_value("wb_we_o", 32'(seen_we), 32'(exp_we));
            if (code == qspi_pkg::CMD_WRITE_THRU)
                check_value("wb_dat_o", 32'(seen_dat), 32'(wdata));
            if (is_read)
                check_value("sio_o read word", 32'(rx_word), 32'(rsp_data));
        end else begin
            check_value("transfer count", 32'(xfer_count), 32'(start_count));
            check_value("wb_cyc_o", 32'(wb_cyc_o), 32'd0);
        end
        if (code == qspi_pkg::CMD_LOOPBACK)
            check_value("sio_o loopback word", 32'(rx_word), 32'(addr[15:0]));
    endtask

    // bus responder acks 1 to 3 cycles after cyc and records the transfer
    initial begin : bus_responder
        int delay;
        xfer_count = 0;
        forever begin
            @(negedge clk_i);
            if (!reset_i && wb_cyc_o === 1'b1) begin
                delay = 1 + ($unsigned($random(seed)) % 3);
                repeat (delay - 1) @(negedge clk_i);
                check_value("wb_stb_o before ack", 32'(wb_stb_o), 32'd1);
                seen_adr   = wb_adr_o;
                seen_we    = wb_we_o;
                seen_dat   = wb_dat_o;
                rsp_data   = 16'($random(seed));
                wb_dat_i   = rsp_data;
                wb_ack_i   = 1'b1;
                xfer_count = xfer_count + 1;
                @(negedge clk_i);
                wb_ack_i = 1'b0;
                check_value("wb_cyc_o after ack", 32'(wb_cyc_o), 32'd0); // one ack only
            end
        end
    end

    initial begin : main
        logic [7:0]  code;
        logic [31:0] addr_word;
        logic [15:0] wdata;
        int          sel;
        int          n;
        seed     = 54564;
        clk_i    = 1'b0;
        reset_i  = 1'b1;
        sck_i    = 1'b0;
        sce_i    = 1'b1;
        sio_i    = 4'h0;
        wb_ack_i = 1'b0;
        wb_dat_i = '0;
        repeat (2) @(negedge clk_i);
        reset_i = 1'b0;
        @(negedge clk_i);
        check_value("wb_cyc_o after reset", 32'(wb_cyc_o), 32'd0);
        check_value("wb_stb_o after reset", 32'(wb_stb_o), 32'd0);
        check_value("sio_oe_o after reset", 32'(sio_oe_o), 32'd0);

        for (n = 0; n < N_TRANS; n++) begin
            sel       = $unsigned($random(seed)) % 6;
            addr_word = $random(seed);
            wdata     = 16'($random(seed));
            case (sel)
                0: code = qspi_pkg::CMD_READ;
                1: code = qspi_pkg::CMD_FAST_READ;
                2: code = qspi_pkg::CMD_SECT_ERASE;
                3: code = qspi_pkg::CMD_WRITE_THRU;
                4: code = qspi_pkg::CMD_LOOPBACK;
                default: begin
                    code = 8'($random(seed));
                    if (is_known_cmd(code))
                        code = 8'h9F; // not a kept code
                end
            endcase
            run_transaction(code, addr_word, wdata);
        end
        $display("Test OK");
        $finish;
    end

endmodule

/* project.f */
nor_bus_pkg.sv
qspi_pkg.sv
qspi_shifter.sv
qspi_cmd_table.sv
qspi_cmd_fsm.sv
wb_master.sv
qspi_flash_bridge.sv
tb_qspi_flash_bridge.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
# exit status is nonzero unless the simulation prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_qspi_flash_bridge -o sim_tb -f project.f &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
